// ==== common/ppu_pkg.sv ====
package ppu_pkg;

    // cpu register map, 3-bit address
    localparam logic [2:0] reg_ctrl     = 3'd0;
    localparam logic [2:0] reg_mask     = 3'd1;
    localparam logic [2:0] reg_status   = 3'd2;
    localparam logic [2:0] reg_oam_addr = 3'd3;
    localparam logic [2:0] reg_oam_data = 3'd4;
    localparam logic [2:0] reg_scroll   = 3'd5;
    localparam logic [2:0] reg_addr     = 3'd6;
    localparam logic [2:0] reg_data     = 3'd7;

    // raster geometry
    localparam int         dots_per_line  = 341;
    localparam logic [8:0] last_dot       = 9'(dots_per_line - 1);
    localparam logic [8:0] vblank_line    = 9'd240;
    localparam logic [8:0] last_line      = 9'd260;
    localparam logic [8:0] prerender_line = 9'h1FF;  // line -1
    localparam logic [8:0] visible_dots   = 9'd256;
    localparam logic [8:0] prefetch_first = 9'd320;  // first two tiles of next line
    localparam logic [8:0] prefetch_last  = 9'd336;

    // vram map
    localparam logic [5:0] palette_page   = 6'h3F;
    localparam logic [1:0] nametable_base = 2'b10;
    localparam logic [3:0] attr_row       = 4'b1111;
    localparam int         vram_addr_w    = 14;

    localparam logic [vram_addr_w-1:0] increment_down = 32;  // one nametable row

    // scroll register, loaded a byte at a time by the cpu,
    // read as tile/pixel fields by the scroll counters
    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } scroll_bytes_t;

    typedef struct packed {
        logic [4:0] coarse_x;
        logic [2:0] fine_x;
        logic [7:0] y;
    } scroll_fields_t;

    typedef union packed {
        scroll_bytes_t  bytes;
        scroll_fields_t fields;
    } scroll_word_t;

endpackage

// ==== design/ppu_regs.sv ====
`timescale 1ns/1ps

module ppu_regs (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [2:0]                         ain,
    input  logic                               read,
    input  logic                               write,
    input  logic [7:0]                         din,
    input  logic [7:0]                         vram_din,
    input  logic                               nmi_flag,
    output logic [7:0]                         dout,
    output logic                               status_read,
    output logic                               rendering_enabled,
    output logic                               nmi_enable,
    output logic                               cpu_access,
    output logic                               cpu_access_read,
    output logic                               cpu_access_write,
    output logic [ppu_pkg::vram_addr_w-1:0]    vram_ptr,
    output ppu_pkg::scroll_word_t              scroll,
    output logic [1:0]                         base_nametable,
    output logic                               bg_pattern_table,
    output logic                               palette_we,
    output logic [4:0]                         palette_index,
    output logic [5:0]                         palette_wdata
);

    logic [7:0]                      ctrl;
    logic [7:0]                      mask;
    logic                            write_toggle;  // shared by scroll and addr
    logic [7:0]                      read_buffer;
    logic                            read_pending;
    logic                            data_sel;
    logic                            in_palette;
    logic [ppu_pkg::vram_addr_w-1:0] ptr_step;

    assign data_sel    = ain == ppu_pkg::reg_data;
    assign in_palette  = vram_ptr[13:8] == ppu_pkg::palette_page;
    assign status_read = read && (ain == ppu_pkg::reg_status);

    assign cpu_access       = data_sel && (read || write);
    assign cpu_access_read  = data_sel && read;
    assign cpu_access_write = data_sel && write && !in_palette;  // palette writes stay inside

    assign palette_we    = data_sel && write && in_palette;
    assign palette_index = vram_ptr[4:0];
    assign palette_wdata = din[5:0];

    assign nmi_enable        = ctrl[7];
    assign bg_pattern_table  = ctrl[4];
    assign base_nametable    = ctrl[1:0];
    assign rendering_enabled = mask[4:3] != 2'b00;  // bg or sprite enable

    assign ptr_step = ctrl[2] ? ppu_pkg::increment_down : 14'd1;

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl         <= 8'd0;
            mask         <= 8'd0;
            write_toggle <= 1'b0;
            vram_ptr     <= '0;
            scroll       <= '0;
        end else begin
            if (status_read)
                write_toggle <= 1'b0;
            if (write) begin
                case (ain)
                    ppu_pkg::reg_ctrl: ctrl <= din;
                    ppu_pkg::reg_mask: mask <= din;
                    ppu_pkg::reg_oam_addr, ppu_pkg::reg_oam_data: ;  // no sprites here
                    ppu_pkg::reg_scroll: begin
                        if (!write_toggle)
                            scroll.bytes.hi <= din;  // x first
                        else
                            scroll.bytes.lo <= din;
                        write_toggle <= !write_toggle;
                    end
                    ppu_pkg::reg_addr: begin
                        if (!write_toggle)
                            vram_ptr[13:8] <= din[5:0];
                        else
                            vram_ptr[7:0] <= din;
                        write_toggle <= !write_toggle;
                    end
                    default: ;
                endcase
            end
            if (cpu_access)
                vram_ptr <= vram_ptr + ptr_step;
        end
    end

    // vram answers one clock after the read strobe
    always_ff @(posedge clk) begin
        if (reset)
            read_pending <= 1'b0;
        else
            read_pending <= cpu_access_read;
    end

    always_ff @(posedge clk) begin
        if (read_pending)
            read_buffer <= vram_din;
    end

    always_comb begin
        if (ain == ppu_pkg::reg_status)
            dout = {nmi_flag, 7'd0};
        else if (data_sel && in_palette)
            dout = 8'd0;
        else
            dout = read_buffer;  // byte from the previous data read
    end

endmodule

// ==== design/ppu_timing.sv ====
`timescale 1ns/1ps

module ppu_timing (
    input  logic       clk,
    input  logic       reset,
    input  logic       rendering_enabled,
    input  logic       status_read,
    output logic [8:0] scanline,
    output logic [8:0] cycle,
    output logic       in_vblank,
    output logic       nmi_flag,
    output logic       render_active
);

    logic odd_frame;
    logic short_line;
    logic end_of_line;
    logic end_of_frame;

    assign render_active = rendering_enabled && !in_vblank &&
                           (scanline != ppu_pkg::vblank_line);

    // odd frames skip the last dot of the pre-render line while rendering
    assign short_line   = odd_frame && render_active && (scanline == ppu_pkg::prerender_line);
    assign end_of_line  = short_line ? (cycle == ppu_pkg::last_dot - 9'd1)
                                     : (cycle == ppu_pkg::last_dot);
    assign end_of_frame = end_of_line && (scanline == ppu_pkg::last_line);

    always_ff @(posedge clk) begin
        if (reset) begin
            scanline  <= 9'd0;
            cycle     <= 9'd0;
            odd_frame <= 1'b0;
            in_vblank <= 1'b1;
            nmi_flag  <= 1'b0;
        end else begin
            cycle <= end_of_line ? 9'd0 : cycle + 9'd1;
            if (end_of_frame) begin
                scanline  <= ppu_pkg::prerender_line;
                odd_frame <= !odd_frame;
            end else if (end_of_line) begin
                scanline <= scanline + 9'd1;  // -1 wraps to 0
            end

            if (end_of_line && scanline == ppu_pkg::vblank_line) begin
                in_vblank <= 1'b1;
                nmi_flag  <= 1'b1;
            end
            if (end_of_frame) begin
                in_vblank <= 1'b0;
                nmi_flag  <= 1'b0;
            end
            // a status read wins over a flag set on the same edge
            if (status_read)
                nmi_flag <= 1'b0;
        end
    end

endmodule

// ==== background/bg_fetch.sv ====
`timescale 1ns/1ps

module bg_fetch (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [8:0]                      cycle,
    input  logic [8:0]                      scanline,
    input  logic                            render_active,
    input  ppu_pkg::scroll_word_t           scroll,
    input  logic [1:0]                      base_nametable,
    input  logic                            bg_pattern_table,
    input  logic                            cpu_access,
    input  logic                            cpu_access_read,
    input  logic                            cpu_access_write,
    input  logic [ppu_pkg::vram_addr_w-1:0] vram_ptr,
    input  logic [7:0]                      vram_din,
    output logic [ppu_pkg::vram_addr_w-1:0] vram_a,
    output logic                            vram_r,
    output logic                            vram_w,
    output logic [4:0]                      coarse_x,
    output logic [7:0]                      tile_row_y
);

    logic [1:0]                      nt_sel;  // current nametable
    logic [7:0]                      tile_num;
    logic [2:0]                      dot_phase;
    logic                            fetch_window;
    logic [ppu_pkg::vram_addr_w-1:0] fetch_addr;

    assign dot_phase    = cycle[2:0] - 3'd1;  // 0 on the first dot of each tile slot
    assign fetch_window = (cycle >= 9'd1 && cycle <= ppu_pkg::visible_dots) ||
                          (cycle >= ppu_pkg::prefetch_first && cycle < ppu_pkg::prefetch_last);

    always_ff @(posedge clk) begin
        if (reset) begin
            coarse_x   <= 5'd0;
            tile_row_y <= 8'd0;
            nt_sel     <= 2'd0;
        end else if (render_active) begin
            // step to the next tile once the attribute byte is in
            if (cycle[2:0] == 3'd4 && fetch_window) begin
                coarse_x <= coarse_x + 5'd1;
                if (coarse_x == 5'd31)
                    nt_sel[0] <= !nt_sel[0];
            end
            if (cycle == 9'd251) begin
                if (tile_row_y == 8'd239) begin  // bottom of the nametable
                    tile_row_y <= 8'd0;
                    nt_sel[1]  <= !nt_sel[1];
                end else begin
                    tile_row_y <= tile_row_y + 8'd1;
                end
            end
            if (cycle == ppu_pkg::prefetch_first) begin
                coarse_x  <= scroll.fields.coarse_x;
                nt_sel[0] <= base_nametable[0];
            end
            // whole scroll position reloads before the first prefetch of a frame
            if (scanline == ppu_pkg::prerender_line && cycle == ppu_pkg::prefetch_first - 9'd1) begin
                coarse_x   <= scroll.fields.coarse_x;
                tile_row_y <= scroll.fields.y;
                nt_sel     <= base_nametable;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (render_active && cycle[2:0] == 3'd2)
            tile_num <= vram_din;  // nametable byte
    end

    always_comb begin
        case (dot_phase[2:1])
            2'd0: fetch_addr = {ppu_pkg::nametable_base, nt_sel, tile_row_y[7:3], coarse_x};
            2'd1: fetch_addr = {ppu_pkg::nametable_base, nt_sel, ppu_pkg::attr_row,
                                tile_row_y[7:5], coarse_x[4:2]};
            2'd2: fetch_addr = {1'b0, bg_pattern_table, tile_num, 1'b0, tile_row_y[2:0]};
            default: fetch_addr = {1'b0, bg_pattern_table, tile_num, 1'b1, tile_row_y[2:0]};
        endcase
    end

    // cpu access owns the bus for its cycle
    assign vram_a = cpu_access ? vram_ptr : fetch_addr;
    assign vram_r = cpu_access ? cpu_access_read : (render_active && cycle[0]);
    assign vram_w = cpu_access_write;

endmodule

// ==== background/bg_shifter.sv ====
`timescale 1ns/1ps

module bg_shifter (
    input  logic       clk,
    input  logic       reset,
    input  logic [8:0] cycle,
    input  logic       render_active,
    input  logic [7:0] vram_din,
    input  logic [4:0] coarse_x,
    input  logic [7:0] tile_row_y,
    output logic [3:0] bg_pixel
);

    logic [7:0]  pat_lo_latch;
    logic [1:0]  attr_latch;
    logic [1:0]  attr_next;   // attribute of the tile waiting in the upper half
    logic [15:0] pat_lo_shift;
    logic [15:0] pat_hi_shift;
    logic [7:0]  attr_lo_shift;
    logic [7:0]  attr_hi_shift;
    logic        shift_window;

    assign shift_window = render_active && cycle >= 9'd1 && cycle <= ppu_pkg::prefetch_last;

    always_ff @(posedge clk) begin
        if (shift_window) begin
            if (cycle[2:0] == 3'd4)
                attr_latch <= vram_din[{tile_row_y[4], coarse_x[1], 1'b0} +: 2];  // quadrant
            if (cycle[2:0] == 3'd6)
                pat_lo_latch <= vram_din;
            if (cycle[2:0] == 3'd0)
                attr_next <= attr_latch;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pat_lo_shift  <= 16'd0;
            pat_hi_shift  <= 16'd0;
            attr_lo_shift <= 8'd0;
            attr_hi_shift <= 8'd0;
        end else if (shift_window) begin
            attr_lo_shift <= {attr_next[0], attr_lo_shift[7:1]};
            attr_hi_shift <= {attr_next[1], attr_hi_shift[7:1]};
            if (cycle[2:0] == 3'd0) begin
                // leftmost pixel goes to the lsb end
                pat_lo_shift <= {{<<{pat_lo_latch}}, pat_lo_shift[8:1]};
                pat_hi_shift <= {{<<{vram_din}}, pat_hi_shift[8:1]};
            end else begin
                pat_lo_shift <= {1'b0, pat_lo_shift[15:1]};
                pat_hi_shift <= {1'b0, pat_hi_shift[15:1]};
            end
        end
    end

    assign bg_pixel = render_active ? {attr_hi_shift[0], attr_lo_shift[0],
                                       pat_hi_shift[0], pat_lo_shift[0]}
                                    : 4'd0;

endmodule

// ==== design/palette_ram.sv ====
`timescale 1ns/1ps

module palette_ram (
    input  logic       clk,
    input  logic       reset,
    input  logic       palette_we,
    input  logic [4:0] palette_index,
    input  logic [5:0] palette_wdata,
    input  logic [3:0] bg_pixel,
    output logic [5:0] color
);

    logic [5:0] entries [0:31];
    logic       write_ignored;

    // 4, 8, 12, 20, 24, 28 do not take writes
    assign write_ignored = (palette_index[1:0] == 2'b00) && (palette_index[3:2] != 2'b00);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                entries[i] <= 6'd0;
        end else if (palette_we && !write_ignored) begin
            entries[palette_index] <= palette_wdata;
        end
    end

    assign color = entries[{1'b0, bg_pixel}];  // background half of the table

endmodule

// ==== design/ppu_top.sv ====
`timescale 1ns/1ps

module ppu_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [2:0]                      ain,
    input  logic                            read,
    input  logic                            write,
    input  logic [7:0]                      din,
    input  logic [7:0]                      vram_din,
    output logic [7:0]                      dout,
    output logic                            nmi,
    output logic [5:0]                      color,
    output logic                            vram_r,
    output logic                            vram_w,
    output logic [ppu_pkg::vram_addr_w-1:0] vram_a,
    output logic [7:0]                      vram_dout,
    output logic [8:0]                      scanline,
    output logic [8:0]                      cycle
);

    logic                            status_read;
    logic                            rendering_enabled;
    logic                            nmi_enable;
    logic                            nmi_flag;
    logic                            render_active;
    logic                            cpu_access;
    logic                            cpu_access_read;
    logic                            cpu_access_write;
    logic [ppu_pkg::vram_addr_w-1:0] vram_ptr;
    ppu_pkg::scroll_word_t           scroll;
    logic [1:0]                      base_nametable;
    logic                            bg_pattern_table;
    logic                            palette_we;
    logic [4:0]                      palette_index;
    logic [5:0]                      palette_wdata;
    logic [4:0]                      coarse_x;
    logic [7:0]                      tile_row_y;
    logic [3:0]                      bg_pixel;

    assign nmi       = nmi_flag && nmi_enable;
    assign vram_dout = din;  // cpu data goes straight out

    ppu_regs u_regs (
        .clk, .reset, .ain, .read, .write, .din, .vram_din, .nmi_flag,
        .dout, .status_read, .rendering_enabled, .nmi_enable,
        .cpu_access, .cpu_access_read, .cpu_access_write, .vram_ptr,
        .scroll, .base_nametable, .bg_pattern_table,
        .palette_we, .palette_index, .palette_wdata
    );

    ppu_timing u_timing (
        .clk, .reset, .rendering_enabled, .status_read,
        .scanline, .cycle, .in_vblank(), .nmi_flag, .render_active
    );

    bg_fetch u_fetch (
        .clk, .reset, .cycle, .scanline, .render_active, .scroll,
        .base_nametable, .bg_pattern_table,
        .cpu_access, .cpu_access_read, .cpu_access_write, .vram_ptr, .vram_din,
        .vram_a, .vram_r, .vram_w, .coarse_x, .tile_row_y
    );

    bg_shifter u_shifter (
        .clk, .reset, .cycle, .render_active, .vram_din, .coarse_x, .tile_row_y,
        .bg_pixel
    );

    palette_ram u_palette (
        .clk, .reset, .palette_we, .palette_index, .palette_wdata, .bg_pixel,
        .color
    );

endmodule

// ==== verification/ppu_tb_clock.sv ====
`timescale 1ns/1ps

module ppu_tb_clock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #2 reset = 1'b0;
    end

endmodule

// ==== verification/ppu_chk.sv ====
`timescale 1ns/1ps

module ppu_chk (
    input logic       clk,
    input logic       reset,
    input logic [2:0] ain,
    input logic       read,
    input logic       vram_r,
    input logic       vram_w,
    input logic [8:0] cycle,
    input logic       nmi
);

    // cpu and fetch never both on the vram strobes
    assert property (@(posedge clk) disable iff (reset) !(vram_r && vram_w))
        else $error("vram_r and vram_w high together");

    assert property (@(posedge clk) disable iff (reset) cycle <= 9'd340)
        else $error("cycle beyond last dot: %0d", cycle);

    // a status read clears the nmi flag at once
    assert property (@(posedge clk) disable iff (reset)
                     (read && ain == ppu_pkg::reg_status) |=> !nmi)
        else $error("nmi still high after a status read");

endmodule

bind ppu_top ppu_chk u_chk (
    .clk(clk), .reset(reset), .ain(ain), .read(read),
    .vram_r(vram_r), .vram_w(vram_w), .cycle(cycle), .nmi(nmi)
);

// ==== verification/ppu_tb.sv ====
`timescale 1ns/1ps

module ppu_tb;

    localparam logic [2:0] k_none = 3'd0;  // no check
    localparam logic [2:0] k_vw   = 3'd1;  // vram write at exp_val
    localparam logic [2:0] k_mem  = 3'd2;  // dout equals model byte at exp_val
    localparam logic [2:0] k_dout = 3'd3;  // dout equals exp_val
    localparam logic [2:0] k_pal  = 3'd4;  // no vram write, color after equals exp_val
    localparam int stim_len = 28;
    localparam int frame_cycles = 262 * 341;
    localparam int limit_ns = (5 * frame_cycles + stim_len * 2 + 100) * 40;

    typedef struct packed {
        logic [2:0]  test;
        logic [2:0]  ain;
        logic        wr;
        logic [7:0]  data;
        logic [2:0]  kind;
        logic [13:0] exp_val;
    } entry_t;

    logic        clk;
    logic        reset;
    logic [2:0]  ain = 3'd0;
    logic        read = 1'b0;
    logic        write = 1'b0;
    logic [7:0]  din = 8'h00;
    logic [7:0]  vram_din = 8'h00;
    logic [7:0]  dout;
    logic        nmi;
    logic [5:0]  color;
    logic        vram_r;
    logic        vram_w;
    logic [13:0] vram_a;
    logic [7:0]  vram_dout;
    logic [8:0]  scanline;
    logic [8:0]  cycle;

    logic [7:0]  mem [0:16383];  // vram model
    integer      seed = 58;
    int          errors = 0;
    int          test_errs [1:6];
    int          n;
    logic [7:0]  got_dout;
    logic        got_w;
    logic        got_nmi;
    logic [13:0] got_a;
    logic [7:0]  got_vdout;
    logic [5:0]  got_color;

    entry_t stim [0:stim_len-1] = '{
        '{3'd3, 3'd0, 1'b1, 8'h00, k_none, 14'h0000},
        '{3'd3, 3'd6, 1'b1, 8'h21, k_none, 14'h0000},
        '{3'd3, 3'd6, 1'b1, 8'h08, k_none, 14'h0000},
        '{3'd3, 3'd7, 1'b1, 8'hA5, k_vw,   14'h2108},
        '{3'd3, 3'd7, 1'b1, 8'h5A, k_vw,   14'h2109},
        '{3'd3, 3'd0, 1'b1, 8'h04, k_none, 14'h0000},  // step by 32
        '{3'd3, 3'd7, 1'b1, 8'h3C, k_vw,   14'h210A},
        '{3'd3, 3'd7, 1'b1, 8'hC3, k_vw,   14'h212A},
        '{3'd4, 3'd0, 1'b1, 8'h00, k_none, 14'h0000},
        '{3'd4, 3'd6, 1'b1, 8'h05, k_none, 14'h0000},
        '{3'd4, 3'd6, 1'b1, 8'h40, k_none, 14'h0000},
        '{3'd4, 3'd7, 1'b0, 8'h00, k_none, 14'h0000},  // primes the buffer
        '{3'd4, 3'd7, 1'b0, 8'h00, k_mem,  14'h0540},
        '{3'd4, 3'd7, 1'b0, 8'h00, k_mem,  14'h0541},
        '{3'd4, 3'd7, 1'b0, 8'h00, k_mem,  14'h0542},
        '{3'd5, 3'd6, 1'b1, 8'h3F, k_none, 14'h0000},
        '{3'd5, 3'd6, 1'b1, 8'h00, k_none, 14'h0000},
        '{3'd5, 3'd7, 1'b1, 8'h2A, k_pal,  14'h002A},
        '{3'd5, 3'd6, 1'b1, 8'h3F, k_none, 14'h0000},
        '{3'd5, 3'd6, 1'b1, 8'h04, k_none, 14'h0000},
        '{3'd5, 3'd7, 1'b1, 8'h11, k_pal,  14'h002A},  // index 4 takes no write
        '{3'd5, 3'd7, 1'b0, 8'h00, k_dout, 14'h0000},  // palette reads give zero
        '{3'd5, 3'd6, 1'b1, 8'h3F, k_none, 14'h0000},
        '{3'd5, 3'd6, 1'b1, 8'h03, k_none, 14'h0000},
        '{3'd5, 3'd7, 1'b1, 8'h16, k_pal,  14'h002A},
        '{3'd5, 3'd6, 1'b1, 8'h3F, k_none, 14'h0000},
        '{3'd5, 3'd6, 1'b1, 8'h0F, k_none, 14'h0000},
        '{3'd5, 3'd7, 1'b1, 8'h30, k_pal,  14'h002A}
    };

    ppu_tb_clock u_clock (.clk, .reset);

    ppu_top u_dut (
        .clk, .reset, .ain, .read, .write, .din, .vram_din,
        .dout, .nmi, .color, .vram_r, .vram_w, .vram_a, .vram_dout, .scanline, .cycle
    );

    always @(posedge clk) begin
        if (vram_r)
            vram_din <= mem[vram_a];  // answers one clock later
    end

    task automatic check(input int t, input string name, input logic [15:0] got,
                         input logic [15:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] test %0d %s: expected %h, got %h", t, name, exp, got);
            test_errs[t]++;
            errors++;
        end
    endtask

    // one access cycle, then one idle cycle
    task automatic bus_cycle(input logic [2:0] a, input logic wr, input logic [7:0] d);
        @(posedge clk);
        #2;
        ain   = a;
        din   = d;
        write = wr;
        read  = !wr;
        @(negedge clk);
        got_dout  = dout;
        got_w     = vram_w;
        got_a     = vram_a;
        got_vdout = vram_dout;
        got_nmi   = nmi;
        if (vram_w)
            mem[vram_a] = vram_dout;  // record the write
        @(posedge clk);
        #2;
        read  = 1'b0;
        write = 1'b0;
        ain   = 3'd0;
        din   = 8'h00;
        @(negedge clk);
        got_color = color;
    endtask

    task automatic wait_line_dot(input logic [8:0] line, input logic [8:0] dot);
        do @(negedge clk); while (!(scanline == line && cycle == dot));
    endtask

    task automatic fill_nametables(input logic [7:0] attr);
        for (int a = 16'h2000; a < 16'h3000; a++)
            mem[a] = ((a & 16'h03C0) == 16'h03C0) ? attr : 8'h00;
    endtask

    task automatic check_line_color(input int t, input logic [5:0] exp);
        while (cycle <= 9'd240) begin
            check(t, "color", 16'(color), 16'(exp));
            @(negedge clk);
        end
    endtask

    task automatic report_test(input int t, input string name);
        $display("test %0d %s: %s", t, name, (test_errs[t] == 0) ? "ok" : "FAILED");
    endtask

    initial begin
        #(limit_ns);
        $display("run timed out before all tests finished");
        $display("Regression failed");
        $finish;
    end

    initial begin
        for (int t = 1; t <= 6; t++)
            test_errs[t] = 0;
        for (int i = 0; i < 16384; i++)
            mem[i] = 8'($random(seed));

        @(negedge clk);
        while (reset) @(negedge clk);
        check(1, "scanline", 16'(scanline), 16'h0000);
        check(1, "cycle", 16'(cycle), 16'h0000);
        check(1, "nmi", 16'(nmi), 16'h0000);
        check(1, "vram_r", 16'(vram_r), 16'h0000);
        check(1, "vram_w", 16'(vram_w), 16'h0000);
        wait_line_dot(9'd241, 9'd0);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (scanline != 9'd0);
        check(1, "dots 241 to 0", 16'(n), 16'(21 * 341));
        report_test(1, "reset and timing");

        bus_cycle(ppu_pkg::reg_ctrl, 1'b1, 8'h80);
        wait_line_dot(9'd240, 9'd340);
        check(2, "nmi", 16'(nmi), 16'h0000);  // still low on the last dot of line 240
        wait_line_dot(9'd241, 9'd0);
        check(2, "nmi", 16'(nmi), 16'h0001);
        bus_cycle(ppu_pkg::reg_status, 1'b0, 8'h00);
        check(2, "dout", 16'(got_dout), 16'h0080);
        bus_cycle(ppu_pkg::reg_status, 1'b0, 8'h00);
        check(2, "dout", 16'(got_dout), 16'h0000);
        check(2, "nmi", 16'(got_nmi), 16'h0000);
        report_test(2, "vblank and nmi");

        for (int i = 0; i < stim_len; i++) begin
            bus_cycle(stim[i].ain, stim[i].wr, stim[i].data);
            case (stim[i].kind)
                k_vw: begin
                    check(stim[i].test, "vram_w", 16'(got_w), 16'h0001);
                    check(stim[i].test, "vram_a", 16'(got_a), 16'(stim[i].exp_val));
                    check(stim[i].test, "vram_dout", 16'(got_vdout), 16'(stim[i].data));
                end
                k_mem: check(stim[i].test, "dout", 16'(got_dout), 16'(mem[stim[i].exp_val]));
                k_dout: check(stim[i].test, "dout", 16'(got_dout), 16'(stim[i].exp_val[7:0]));
                k_pal: begin
                    check(stim[i].test, "vram_w", 16'(got_w), 16'h0000);
                    check(stim[i].test, "color", 16'(got_color), 16'(stim[i].exp_val[5:0]));
                end
                default: ;
            endcase
        end
        report_test(3, "address pointer writes");
        report_test(4, "buffered reads");

        // patterns all zero and attribute 01 everywhere, so the pixel is 4
        for (int a = 0; a < 16'h2000; a++)
            mem[a] = 8'h00;
        fill_nametables(8'h55);
        bus_cycle(ppu_pkg::reg_mask, 1'b1, 8'h08);
        wait_line_dot(9'd10, 9'd20);
        check_line_color(5, 6'h00);  // entry 4 keeps its reset value
        report_test(5, "palette");

        // nametable 0, patterns all ones, so the pixel is {attr, 2'b11}
        for (int a = 0; a < 16'h2000; a++)
            mem[a] = 8'hFF;
        fill_nametables(8'h00);
        wait_line_dot(9'd11, 9'd0);
        wait_line_dot(9'd10, 9'd20);
        check_line_color(6, 6'h16);  // entry 3
        fill_nametables(8'hFF);
        wait_line_dot(9'd11, 9'd0);
        wait_line_dot(9'd10, 9'd20);
        check_line_color(6, 6'h30);  // entry 15
        report_test(6, "background render");

        n = 0;
        for (int t = 1; t <= 6; t++)
            if (test_errs[t] == 0)
                n++;
        $display("tests passed %0d of 6, failed checks %0d", n, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== project.f ====
common/ppu_pkg.sv
design/ppu_regs.sv
design/ppu_timing.sv
background/bg_fetch.sv
background/bg_shifter.sv
design/palette_ram.sv
design/ppu_top.sv
verification/ppu_tb_clock.sv
verification/ppu_chk.sv
verification/ppu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = ppu_tb
FILELIST  = project.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)_sim
	out=$$(./obj_dir/$(TOP)_sim); echo "$$out"; echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir
